// ==== x86_isa_pkg.sv ====
`default_nettype none

package x86_isa_pkg;

    // Data widths
    typedef logic [7:0]  byte_t;    // Opcodes, immediates, port data
    typedef logic [15:0] word_t;    // Register value
    typedef logic [11:0] flags_t;   // 8086 flags word
    typedef logic [2:0]  reg_idx_t; // Register number, 8086 encoding

    // ALU operations in opcode bits 5:3 order
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_OR,
        ALU_ADC,
        ALU_SBB,
        ALU_AND,
        ALU_SUB,
        ALU_XOR,
        ALU_CMP
    } alu_op_t;

    // Instruction classes handled by the core
    typedef enum logic [3:0] {
        ALU_RM,         // <alu> r, r
        ALU_ACC_IMM,    // <alu> AL/AX, imm
        MOV_IMM,        // MOV r, imm
        INCDEC,         // INC/DEC r16
        JCC,            // Jcc rel8
        JMP_SHORT,      // JMP rel8
        FLAG_OP,        // CLC, STC, CMC
        LAHF,
        OUT_IMM,        // OUT imm8, AL/AX
        HALT            // HLT and anything unknown
    } instr_class_t;

    // Flag bit positions
    localparam int FLAG_CF = 0;
    localparam int FLAG_PF = 2;
    localparam int FLAG_AF = 4;
    localparam int FLAG_ZF = 6;
    localparam int FLAG_SF = 7;
    localparam int FLAG_OF = 11;

    // Register numbers
    localparam reg_idx_t REG_AX = 3'd0;
    localparam reg_idx_t REG_CX = 3'd1;
    localparam reg_idx_t REG_DX = 3'd2;
    localparam reg_idx_t REG_BX = 3'd3;
    localparam reg_idx_t REG_AH = 3'd4; // Same code as SP in 16-bit form

endpackage

`default_nettype wire

// ==== x86_core_pkg.sv ====
`default_nettype none

package x86_core_pkg;

    typedef logic [15:0] addr_t; // Fetch address, IP only

    // Sequencer states, one cycle each except the port states
    typedef enum logic [2:0] {
        FETCH,
        MODRM,
        IMM_LO,
        IMM_HI,
        EXEC,
        PORT_LO,
        PORT_HI,
        HALTED
    } seq_state_t;

    localparam addr_t RESET_IP = 16'h0000;

endpackage

`default_nettype wire

// ==== x86_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module x86_alu
    import x86_isa_pkg::*;
(
    input  wire alu_op_t i_op,
    input  wire          i_wide,
    input  wire word_t   i_a,
    input  wire word_t   i_b,
    input  wire flags_t  i_flags,
    output word_t        o_result,
    output flags_t       o_flags
);

    logic [16:0] a_x;   // Operands with room for the carry
    logic [16:0] b_x;
    logic [16:0] res;
    logic        arith; // Low for OR, AND, XOR
    logic        sub_op;
    logic        a_top;
    logic        b_top;
    logic        r_top;
    logic        carry;

    assign a_x = i_wide ? {1'b0, i_a} : {9'h000, i_a[7:0]};
    assign b_x = i_wide ? {1'b0, i_b} : {9'h000, i_b[7:0]};

    always_comb begin
        arith = 1'b1;
        case (i_op)
            ALU_ADD:          res = a_x + b_x;
            ALU_ADC:          res = a_x + b_x + {16'h0000, i_flags[FLAG_CF]};
            ALU_SBB:          res = a_x - b_x - {16'h0000, i_flags[FLAG_CF]};
            ALU_SUB, ALU_CMP: res = a_x - b_x;
            ALU_OR: begin
                res   = a_x | b_x;
                arith = 1'b0;
            end
            ALU_AND: begin
                res   = a_x & b_x;
                arith = 1'b0;
            end
            default: begin
                res   = a_x ^ b_x;
                arith = 1'b0;
            end
        endcase
    end

    // Sign and carry positions depend on the width
    assign sub_op = (i_op == ALU_SUB) || (i_op == ALU_SBB) || (i_op == ALU_CMP);
    assign a_top  = i_wide ? a_x[15] : a_x[7];
    assign b_top  = i_wide ? b_x[15] : b_x[7];
    assign r_top  = i_wide ? res[15] : res[7];
    assign carry  = i_wide ? res[16] : res[8]; // Borrow for subtraction

    assign o_result = i_wide ? res[15:0] : {8'h00, res[7:0]};

    always_comb begin
        o_flags          = i_flags; // Untouched bits pass through
        o_flags[FLAG_CF] = arith & carry;
        o_flags[FLAG_AF] = arith & (a_x[4] ^ b_x[4] ^ res[4]);
        if (sub_op) begin
            o_flags[FLAG_OF] = (a_top ^ b_top) & (a_top ^ r_top);
        end else begin
            o_flags[FLAG_OF] = arith & ~(a_top ^ b_top) & (a_top ^ r_top);
        end
        o_flags[FLAG_SF] = r_top;
        o_flags[FLAG_ZF] = (o_result == 16'h0000);
        o_flags[FLAG_PF] = ~^res[7:0];  // Low byte only
    end

endmodule

`default_nettype wire

// ==== x86_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module x86_regfile
    import x86_isa_pkg::*;
(
    input  wire           clock,
    input  wire           i_rst_n,
    // Register write port
    input  wire           i_we,
    input  wire reg_idx_t i_widx,
    input  wire           i_wide,
    input  wire word_t    i_wdata,
    // Flags write port
    input  wire           i_fwe,
    input  wire flags_t   i_fdata,
    output word_t [7:0]   o_regs,
    output flags_t        o_flags
);

    word_t [7:0] regs_q;
    flags_t      flags_q;

    // ----------------------------------------
    // General registers
    // ----------------------------------------
    always_ff @(posedge clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            regs_q <= '0;
        end else if (i_we) begin
            if (i_wide) begin
                regs_q[i_widx] <= i_wdata;
            end else if (i_widx[2]) begin
                regs_q[i_widx[1:0]][15:8] <= i_wdata[7:0]; // AH, CH, DH, BH
            end else begin
                regs_q[i_widx[1:0]][7:0] <= i_wdata[7:0];  // AL, CL, DL, BL
            end
        end
    end

    // Flags
    always_ff @(posedge clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            flags_q <= '0;
        end else if (i_fwe) begin
            flags_q <= i_fdata;
        end
    end

    assign o_regs  = regs_q;
    assign o_flags = flags_q;

endmodule

`default_nettype wire

// ==== x86_opcode_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module x86_opcode_decoder
    import x86_isa_pkg::*;
(
    input  wire byte_t    i_opcode,
    output instr_class_t  o_class,
    output alu_op_t       o_alu_op,
    output logic          o_wide,
    output logic          o_dir,       // 1: reg field is the destination
    output logic          o_has_modrm,
    output logic [1:0]    o_imm_bytes
);

    always_comb begin
        o_class     = HALT;
        o_alu_op    = alu_op_t'(i_opcode[5:3]);
        o_wide      = i_opcode[0];
        o_dir       = i_opcode[1];
        o_has_modrm = 1'b0;
        o_imm_bytes = 2'd0;

        casez (i_opcode)
            8'b00???0??: begin
                o_class     = ALU_RM;
                o_has_modrm = 1'b1;
            end
            8'b00???10?: begin
                o_class     = ALU_ACC_IMM;
                o_imm_bytes = i_opcode[0] ? 2'd2 : 2'd1;
            end
            8'b0100????: begin
                o_class  = INCDEC;
                o_alu_op = i_opcode[3] ? ALU_SUB : ALU_ADD;
                o_wide   = 1'b1; // Always r16
            end
            8'b0111????: begin
                o_class     = JCC;
                o_imm_bytes = 2'd1;
            end
            8'b1011????: begin
                o_class     = MOV_IMM;
                o_wide      = i_opcode[3];
                o_imm_bytes = i_opcode[3] ? 2'd2 : 2'd1;
            end
            8'b11101011: begin
                o_class     = JMP_SHORT;
                o_imm_bytes = 2'd1;
            end
            8'b1110011?: begin
                o_class     = OUT_IMM;
                o_imm_bytes = 2'd1; // Port number
            end
            8'b1111100?, 8'b11110101: o_class = FLAG_OP; // CLC, STC, CMC
            8'b10011111:              o_class = LAHF;
            default:                  o_class = HALT;
        endcase
    end

endmodule

`default_nettype wire

// ==== x86_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module x86_sequencer
    import x86_isa_pkg::*;
    import x86_core_pkg::*;
(
    input  wire               clock,
    input  wire               i_rst_n,
    // Instruction memory
    input  wire byte_t        i_mem_data,
    output addr_t             o_mem_addr,
    // Decoder
    output byte_t             o_opcode,
    input  wire instr_class_t i_class,
    input  wire alu_op_t      i_alu_op,
    input  wire               i_wide,
    input  wire               i_dir,
    input  wire               i_has_modrm,
    input  wire [1:0]         i_imm_bytes,
    // ALU
    output alu_op_t           o_alu_op,
    output logic              o_alu_wide,
    output word_t             o_alu_a,
    output word_t             o_alu_b,
    input  wire word_t        i_alu_result,
    input  wire flags_t       i_alu_flags,
    // Register file
    input  wire word_t [7:0]  i_regs,
    input  wire flags_t       i_flags,
    output logic              o_we,
    output reg_idx_t          o_widx,
    output logic              o_wide,
    output word_t             o_wdata,
    output logic              o_fwe,
    output flags_t            o_fdata,
    // Port output
    output logic              o_port_valid,
    output byte_t             o_port_addr,
    output byte_t             o_port_data,
    input  wire               i_port_ready,
    output logic              o_halted
);

    seq_state_t   state;
    addr_t        ip;
    byte_t        opcode_q;
    instr_class_t cls_q;
    alu_op_t      alu_op_q;
    logic         wide_q;
    logic         dir_q;
    logic [1:0]   imm_bytes_q;
    reg_idx_t     dst_q;
    word_t        op_a;
    word_t        op_b;
    word_t        imm_q;   // Sign-extended after IMM_LO
    logic [7:0]   jcc_cond;
    logic         jcc_taken;

    // 8-bit index 4..7 selects the high byte of AX..BX
    function automatic word_t read_reg(input reg_idx_t idx, input logic wide);
        if (wide) begin
            return i_regs[idx];
        end
        return idx[2] ? {8'h00, i_regs[idx[1:0]][15:8]} : {8'h00, i_regs[idx[1:0]][7:0]};
    endfunction

    // ----------------------------------------
    // State and IP
    // ----------------------------------------
    always_ff @(posedge clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= FETCH;
            ip    <= RESET_IP;
        end else begin
            case (state)
                FETCH: begin
                    ip <= ip + 1'b1;
                    if (i_class == HALT) begin
                        state <= HALTED;
                    end else if (i_has_modrm) begin
                        state <= MODRM;
                    end else if (i_imm_bytes != 2'd0) begin
                        state <= IMM_LO;
                    end else begin
                        state <= EXEC;
                    end
                end
                MODRM: begin
                    ip    <= ip + 1'b1;
                    state <= EXEC;
                end
                IMM_LO: begin
                    ip    <= ip + 1'b1;
                    state <= (imm_bytes_q == 2'd2) ? IMM_HI : EXEC;
                end
                IMM_HI: begin
                    ip    <= ip + 1'b1;
                    state <= EXEC;
                end
                EXEC: begin
                    state <= (cls_q == OUT_IMM) ? PORT_LO : FETCH;
                    if (cls_q == JMP_SHORT || (cls_q == JCC && jcc_taken)) begin
                        ip <= ip + imm_q; // IP already past the displacement
                    end
                end
                PORT_LO: if (i_port_ready) state <= wide_q ? PORT_HI : FETCH;
                PORT_HI: if (i_port_ready) state <= FETCH;
                default: state <= HALTED;  // Held until reset
            endcase
        end
    end

    // Decode fields, operands and immediate
    always_ff @(posedge clock) begin
        case (state)
            FETCH: begin
                opcode_q    <= i_mem_data;
                cls_q       <= i_class;
                alu_op_q    <= i_alu_op;
                wide_q      <= i_wide;
                dir_q       <= i_dir;
                imm_bytes_q <= i_imm_bytes;
                dst_q       <= (i_class == ALU_ACC_IMM) ? REG_AX : i_mem_data[2:0];
                op_a        <= read_reg((i_class == ALU_ACC_IMM) ? REG_AX : i_mem_data[2:0],
                                        i_wide);
                op_b        <= 16'h0001; // INC/DEC step
            end
            MODRM: begin
                dst_q <= dir_q ? i_mem_data[5:3] : i_mem_data[2:0];
                op_a  <= read_reg(dir_q ? i_mem_data[5:3] : i_mem_data[2:0], wide_q);
                op_b  <= read_reg(dir_q ? i_mem_data[2:0] : i_mem_data[5:3], wide_q);
            end
            IMM_LO: imm_q <= {{8{i_mem_data[7]}}, i_mem_data};
            IMM_HI: imm_q[15:8] <= i_mem_data;
            EXEC:   if (cls_q == OUT_IMM) op_a <= i_regs[REG_AX];
            default: ;
        endcase
    end

    // Jcc conditions by opcode bits 3:1, bit 0 inverts
    assign jcc_cond = {
        (i_flags[FLAG_SF] ^ i_flags[FLAG_OF]) | i_flags[FLAG_ZF], // JLE
        i_flags[FLAG_SF] ^ i_flags[FLAG_OF],                      // JL
        i_flags[FLAG_PF],
        i_flags[FLAG_SF],
        i_flags[FLAG_CF] | i_flags[FLAG_ZF],                      // JBE
        i_flags[FLAG_ZF],
        i_flags[FLAG_CF],
        i_flags[FLAG_OF]
    };
    assign jcc_taken = jcc_cond[opcode_q[3:1]] ^ opcode_q[0];

    // ----------------------------------------
    // Writeback in EXEC
    // ----------------------------------------
    always_comb begin
        o_we    = 1'b0;
        o_widx  = dst_q;
        o_wide  = wide_q;
        o_wdata = i_alu_result;
        o_fwe   = 1'b0;
        o_fdata = i_alu_flags;
        if (state == EXEC) begin
            case (cls_q)
                ALU_RM, ALU_ACC_IMM: begin
                    o_we  = (alu_op_q != ALU_CMP); // CMP sets flags only
                    o_fwe = 1'b1;
                end
                INCDEC: begin
                    o_we             = 1'b1;
                    o_fwe            = 1'b1;
                    o_fdata[FLAG_CF] = i_flags[FLAG_CF];
                end
                MOV_IMM: begin
                    o_we    = 1'b1;
                    o_wdata = imm_q;
                end
                FLAG_OP: begin
                    o_fwe            = 1'b1;
                    o_fdata          = i_flags;
                    o_fdata[FLAG_CF] = opcode_q[3] ? opcode_q[0] : ~i_flags[FLAG_CF];
                end
                LAHF: begin
                    o_we    = 1'b1;
                    o_widx  = REG_AH;
                    o_wide  = 1'b0;
                    o_wdata = {8'h00, i_flags[7:2], 1'b1, i_flags[0]};
                end
                default: ;
            endcase
        end
    end

    assign o_mem_addr = ip;
    assign o_opcode   = i_mem_data; // Only sampled in FETCH

    assign o_alu_op   = alu_op_q;
    assign o_alu_wide = wide_q;
    assign o_alu_a    = op_a;
    assign o_alu_b    = (cls_q == ALU_ACC_IMM) ? imm_q : op_b;

    // AX held in op_a during the port states
    assign o_port_valid = (state == PORT_LO) || (state == PORT_HI);
    assign o_port_addr  = imm_q[7:0];
    assign o_port_data  = (state == PORT_HI) ? op_a[15:8] : op_a[7:0];
    assign o_halted     = (state == HALTED);

endmodule

`default_nettype wire

// ==== x86_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module x86_core
    import x86_isa_pkg::*;
    import x86_core_pkg::*;
(
    input  wire        clock,
    input  wire        i_rst_n,
    input  wire byte_t i_mem_data,
    output addr_t      o_mem_addr,
    output logic       o_port_valid,
    output byte_t      o_port_addr,
    output byte_t      o_port_data,
    input  wire        i_port_ready,
    output logic       o_halted
);

    // Decode
    byte_t        opcode;
    instr_class_t dec_class;
    alu_op_t      dec_alu_op;
    logic         dec_wide;
    logic         dec_dir;
    logic         dec_has_modrm;
    logic [1:0]   dec_imm_bytes;

    // ALU
    alu_op_t      alu_op;
    logic         alu_wide;
    word_t        alu_a;
    word_t        alu_b;
    word_t        alu_result;
    flags_t       alu_flags;

    // Register file
    word_t [7:0]  regs;
    flags_t       flags;
    logic         rf_we;
    reg_idx_t     rf_widx;
    logic         rf_wide;
    word_t        rf_wdata;
    logic         rf_fwe;
    flags_t       rf_fdata;

    x86_opcode_decoder u_decoder (
        .i_opcode    (opcode),
        .o_class     (dec_class),
        .o_alu_op    (dec_alu_op),
        .o_wide      (dec_wide),
        .o_dir       (dec_dir),
        .o_has_modrm (dec_has_modrm),
        .o_imm_bytes (dec_imm_bytes)
    );

    x86_sequencer u_sequencer (
        .clock        (clock),
        .i_rst_n      (i_rst_n),
        .i_mem_data   (i_mem_data),
        .o_mem_addr   (o_mem_addr),
        .o_opcode     (opcode),
        .i_class      (dec_class),
        .i_alu_op     (dec_alu_op),
        .i_wide       (dec_wide),
        .i_dir        (dec_dir),
        .i_has_modrm  (dec_has_modrm),
        .i_imm_bytes  (dec_imm_bytes),
        .o_alu_op     (alu_op),
        .o_alu_wide   (alu_wide),
        .o_alu_a      (alu_a),
        .o_alu_b      (alu_b),
        .i_alu_result (alu_result),
        .i_alu_flags  (alu_flags),
        .i_regs       (regs),
        .i_flags      (flags),
        .o_we         (rf_we),
        .o_widx       (rf_widx),
        .o_wide       (rf_wide),
        .o_wdata      (rf_wdata),
        .o_fwe        (rf_fwe),
        .o_fdata      (rf_fdata),
        .o_port_valid (o_port_valid),
        .o_port_addr  (o_port_addr),
        .o_port_data  (o_port_data),
        .i_port_ready (i_port_ready),
        .o_halted     (o_halted)
    );

    x86_alu u_alu (
        .i_op     (alu_op),
        .i_wide   (alu_wide),
        .i_a      (alu_a),
        .i_b      (alu_b),
        .i_flags  (flags), // Carry-in for ADC and SBB
        .o_result (alu_result),
        .o_flags  (alu_flags)
    );

    x86_regfile u_regfile (
        .clock   (clock),
        .i_rst_n (i_rst_n),
        .i_we    (rf_we),
        .i_widx  (rf_widx),
        .i_wide  (rf_wide),
        .i_wdata (rf_wdata),
        .i_fwe   (rf_fwe),
        .i_fdata (rf_fdata),
        .o_regs  (regs),
        .o_flags (flags)
    );

endmodule

`default_nettype wire

// ==== tb_x86_core_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module x86_core_sva
    import x86_isa_pkg::*;
(
    input wire        clock,
    input wire        i_rst_n,
    input wire        o_port_valid,
    input wire byte_t o_port_addr,
    input wire byte_t o_port_data,
    input wire        i_port_ready,
    input wire        o_halted
);

    // Request holds with a stable payload until it is taken
    port_hold: assert property (
        @(posedge clock) disable iff (!i_rst_n)
        o_port_valid && !i_port_ready |=>
            o_port_valid && $stable(o_port_addr) && $stable(o_port_data)
    ) else $error("port request dropped or changed before ready");

    port_idle_in_reset: assert property (
        @(posedge clock) !i_rst_n |-> !o_port_valid
    ) else $error("o_port_valid high during reset");

    // Halt is sticky and no new output follows it
    port_quiet_when_halted: assert property (
        @(posedge clock) disable iff (!i_rst_n)
        o_halted |=> o_halted && !o_port_valid
    ) else $error("core left halt or raised o_port_valid after halting");

endmodule

bind x86_core x86_core_sva sva0 (
    .clock        (clock),
    .i_rst_n      (i_rst_n),
    .o_port_valid (o_port_valid),
    .o_port_addr  (o_port_addr),
    .o_port_data  (o_port_data),
    .i_port_ready (i_port_ready),
    .o_halted     (o_halted)
);

`default_nettype wire

// ==== tb_x86_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_x86_core
    import x86_isa_pkg::*;
    import x86_core_pkg::*;
();

    localparam int SEED        = 66811;
    localparam int NUM_TESTS   = 24;
    localparam int HALT_CYCLES = 4000; // Per program

    logic  clock;
    logic  rst_n;
    byte_t mem_data;
    addr_t mem_addr;
    logic  port_valid;
    byte_t port_addr;
    byte_t port_data;
    logic  port_ready;
    logic  halted;

    byte_t mem [0:65535];

    // Reference model state
    word_t  m_regs [0:7];
    flags_t m_flags;
    byte_t  exp_addr [$];
    byte_t  exp_data [$];

    int errors;
    int checks;
    int seen;      // Transfers taken in the current test

    x86_core dut0 (
        .clock        (clock),
        .i_rst_n      (rst_n),
        .i_mem_data   (mem_data),
        .o_mem_addr   (mem_addr),
        .o_port_valid (port_valid),
        .o_port_addr  (port_addr),
        .o_port_data  (port_data),
        .i_port_ready (port_ready),
        .o_halted     (halted)
    );

    assign mem_data = mem[mem_addr]; // Same-cycle read

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic int instr_len(input byte_t op);
        if (op[7:6] == 2'b00 && !op[2]) return 2;       // ModRM
        if (op[7:6] == 2'b00) return op[0] ? 3 : 2;     // Accumulator with imm
        if (op[7:4] == 4'hb) return op[3] ? 3 : 2;      // MOV r, imm
        if (op[7:4] == 4'h7 || op == 8'heb || op[7:1] == 7'b1110011) return 2;
        return 1;
    endfunction

    // AL..BL are 0..3 and AH..BH are 4..7
    function automatic word_t get_reg(input reg_idx_t idx, input logic wide);
        word_t r;
        r = m_regs[{1'b0, idx[1:0]}];
        if (wide) return m_regs[idx];
        return idx[2] ? {8'h00, r[15:8]} : {8'h00, r[7:0]};
    endfunction

    task automatic set_reg(input reg_idx_t idx, input logic wide, input word_t val);
        if (wide) begin
            m_regs[idx] = val;
        end else if (idx[2]) begin
            m_regs[{1'b0, idx[1:0]}][15:8] = val[7:0];
        end else begin
            m_regs[{1'b0, idx[1:0]}][7:0] = val[7:0];
        end
    endtask

    task automatic alu_model(input alu_op_t op, input logic wide, input word_t a,
                             input word_t b, output word_t r);
        logic [31:0] mask;
        logic [31:0] msb;
        logic [31:0] ua;
        logic [31:0] ub;
        logic [31:0] cin;
        logic [31:0] full;
        logic        logic_op;
        mask     = wide ? 32'h0000_ffff : 32'h0000_00ff;
        msb      = wide ? 32'h0000_8000 : 32'h0000_0080;
        ua       = {16'h0000, a} & mask;
        ub       = {16'h0000, b} & mask;
        cin      = (op == ALU_ADC || op == ALU_SBB) ? {31'd0, m_flags[FLAG_CF]} : 32'd0;
        logic_op = (op == ALU_OR || op == ALU_AND || op == ALU_XOR);
        case (op)
            ALU_ADD, ALU_ADC: full = ua + ub + cin;
            ALU_OR:           full = ua | ub;
            ALU_AND:          full = ua & ub;
            ALU_XOR:          full = ua ^ ub;
            default:          full = ua - ub - cin; // SUB, SBB, CMP
        endcase
        r = full[15:0] & mask[15:0];
        if (logic_op) begin
            m_flags[FLAG_CF] = 1'b0;
            m_flags[FLAG_AF] = 1'b0;
            m_flags[FLAG_OF] = 1'b0;
        end else begin
            if (op == ALU_ADD || op == ALU_ADC) begin
                m_flags[FLAG_CF] = (full > mask);
                m_flags[FLAG_OF] = ((ua ^ full) & (ub ^ full) & msb) != 0; // Same signs in
            end else begin
                m_flags[FLAG_CF] = (ua < ub + cin);                        // Borrow
                m_flags[FLAG_OF] = ((ua ^ ub) & (ua ^ full) & msb) != 0;
            end
            m_flags[FLAG_AF] = ((ua ^ ub ^ full) & 32'h10) != 0;
        end
        m_flags[FLAG_SF] = (r & msb[15:0]) != 0;
        m_flags[FLAG_ZF] = (r == 16'h0000);
        m_flags[FLAG_PF] = ~^r[7:0];
    endtask

    function automatic logic jump_taken(input logic [3:0] cc);
        logic c;
        case (cc[3:1])
            3'd0:    c = m_flags[FLAG_OF];
            3'd1:    c = m_flags[FLAG_CF];
            3'd2:    c = m_flags[FLAG_ZF];
            3'd3:    c = m_flags[FLAG_CF] | m_flags[FLAG_ZF];
            3'd4:    c = m_flags[FLAG_SF];
            3'd5:    c = m_flags[FLAG_PF];
            3'd6:    c = m_flags[FLAG_SF] ^ m_flags[FLAG_OF];
            default: c = (m_flags[FLAG_SF] ^ m_flags[FLAG_OF]) | m_flags[FLAG_ZF];
        endcase
        return c ^ cc[0]; // Odd codes negate
    endfunction

    task automatic run_model(output int steps);
        addr_t    ip;
        byte_t    op;
        byte_t    b1;
        word_t    imm;
        word_t    r;
        alu_op_t  aop;
        reg_idx_t dst;
        reg_idx_t src;
        logic     c;
        logic     done;
        int       i;
        for (i = 0; i < 8; i++) m_regs[i] = '0;
        m_flags = '0;
        ip      = RESET_IP;
        done    = 1'b0;
        steps   = 0;
        while (!done && steps < 1000) begin
            op    = mem[ip];
            b1    = mem[ip + 16'd1];
            imm   = {mem[ip + 16'd2], b1};
            aop   = alu_op_t'(op[5:3]);
            ip    = ip + 16'(instr_len(op));
            steps++;
            if (op[7:6] == 2'b00 && !op[2]) begin
                dst = op[1] ? b1[5:3] : b1[2:0];
                src = op[1] ? b1[2:0] : b1[5:3];
                alu_model(aop, op[0], get_reg(dst, op[0]), get_reg(src, op[0]), r);
                if (aop != ALU_CMP) set_reg(dst, op[0], r);
            end else if (op[7:6] == 2'b00 && op[2:1] == 2'b10) begin
                alu_model(aop, op[0], get_reg(REG_AX, op[0]), imm, r);
                if (aop != ALU_CMP) set_reg(REG_AX, op[0], r);
            end else if (op[7:4] == 4'h4) begin
                c = m_flags[FLAG_CF]; // INC/DEC leave CF alone
                alu_model(op[3] ? ALU_SUB : ALU_ADD, 1'b1, m_regs[op[2:0]], 16'h0001, r);
                m_flags[FLAG_CF] = c;
                m_regs[op[2:0]]  = r;
            end else if (op[7:4] == 4'hb) begin
                set_reg(op[2:0], op[3], imm);
            end else if (op[7:4] == 4'h7 || op == 8'heb) begin
                if (op == 8'heb || jump_taken(op[3:0])) ip = ip + {{8{b1[7]}}, b1};
            end else if (op[7:1] == 7'b1110011) begin
                exp_addr.push_back(b1);
                exp_data.push_back(m_regs[REG_AX][7:0]);
                if (op[0]) begin
                    exp_addr.push_back(b1);
                    exp_data.push_back(m_regs[REG_AX][15:8]);
                end
            end else if (op == 8'hf8 || op == 8'hf9) begin
                m_flags[FLAG_CF] = op[0];
            end else if (op == 8'hf5) begin
                m_flags[FLAG_CF] = ~m_flags[FLAG_CF];
            end else if (op == 8'h9f) begin
                m_regs[REG_AX][15:8] = {m_flags[FLAG_SF], m_flags[FLAG_ZF], 1'b0,
                                        m_flags[FLAG_AF], 1'b0, m_flags[FLAG_PF], 1'b1,
                                        m_flags[FLAG_CF]};
            end else begin
                done = 1'b1; // HLT
            end
        end
    endtask

    // ----------------------------------------
    // Program generator
    // ----------------------------------------
    task automatic build_program(output int count);
        byte_t ops [$];
        addr_t pc;
        int    a;
        int    i;
        int    k;
        int    skip;
        int    disp;
        for (a = 0; a < 65536; a++) mem[a[15:0]] = a[15:8] ^ a[7:0] ^ 8'h5a;
        count = 16 + int'($urandom % 24);
        for (i = 0; i < count; i++) begin
            case ($urandom % 12)
                0, 1: ops.push_back({2'b00, 3'($urandom), 1'b0, 2'($urandom)});
                2:    ops.push_back({2'b00, 3'($urandom), 2'b10, 1'($urandom)});
                3:    ops.push_back({4'h4, 4'($urandom)});
                4:    ops.push_back({4'hb, 4'($urandom)});
                5:    ops.push_back({4'h7, 4'($urandom)});
                6:    ops.push_back(8'heb);
                7: begin
                    k = int'($urandom % 3);
                    ops.push_back(k == 0 ? 8'hf8 : (k == 1 ? 8'hf9 : 8'hf5));
                end
                8: begin // Flags out through AH
                    ops.push_back(8'h9f);
                    ops.push_back(8'he7);
                end
                9: begin
                    ops.push_back({4'hb, 4'($urandom)});
                    ops.push_back({7'b1110011, 1'($urandom)});
                end
                default: ops.push_back({7'b1110011, 1'($urandom)});
            endcase
        end
        ops.push_back(8'hf4);
        count = ops.size();

        pc = RESET_IP;
        for (i = 0; i < ops.size(); i++) begin
            mem[pc] = ops[i];
            for (k = 1; k < instr_len(ops[i]); k++) mem[pc + 16'(k)] = 8'($urandom);
            if (ops[i][7:6] == 2'b00 && !ops[i][2]) mem[pc + 16'd1][7:6] = 2'b11;
            // Forward over up to three instructions and never past HLT
            if (ops[i] == 8'heb || ops[i][7:4] == 4'h7) begin
                skip = int'($urandom % 4);
                disp = 0;
                for (k = i + 1; k <= i + skip && k < ops.size() - 1; k++) begin
                    disp += instr_len(ops[k]);
                end
                mem[pc + 16'd1] = disp[7:0];
            end
            pc = pc + 16'(instr_len(ops[i]));
        end
    endtask

    // ----------------------------------------
    // Reset, run and monitor
    // ----------------------------------------
    task automatic apply_reset();
        @(negedge clock);
        rst_n      = 1'b0;
        port_ready = 1'b0;
        seen       = 0;
        repeat (16) @(negedge clock);
        check_value("o_port_valid", 0, int'(port_valid));
        check_value("o_halted", 0, int'(halted));
        check_value("o_mem_addr", 0, int'(mem_addr));
        rst_n = 1'b1;
    endtask

    task automatic wait_for_halt(output logic timed_out);
        int cycles;
        cycles = 0;
        while (!halted && cycles < HALT_CYCLES) begin
            @(negedge clock);
            port_ready = ($urandom % 4) != 0; // Back-pressure one cycle in four
            cycles++;
        end
        timed_out = !halted;
    endtask

    always @(posedge clock) begin
        if (rst_n && port_valid && port_ready) begin
            seen++;
            if (exp_addr.size() == 0) begin
                errors++;
                $display("Port transfer at %0t ns that the model does not expect", $time);
            end else begin
                check_value("o_port_addr", int'(exp_addr.pop_front()), int'(port_addr));
                check_value("o_port_data", int'(exp_data.pop_front()), int'(port_data));
            end
        end
    end

    initial begin
        int   t;
        int   n_instr;
        int   steps;
        int   exp_count;
        int   errors_before;
        logic timed_out;
        void'($urandom(SEED));
        rst_n      = 1'b0;
        port_ready = 1'b0;
        errors     = 0;
        checks     = 0;
        seen       = 0;
        timed_out  = 1'b0;
        for (t = 0; t < NUM_TESTS && !timed_out; t++) begin
            errors_before = errors;
            build_program(n_instr);
            exp_addr.delete();
            exp_data.delete();
            run_model(steps);
            exp_count = exp_addr.size();
            apply_reset();
            wait_for_halt(timed_out);
            if (timed_out) begin
                errors++;
                $display("Test %0d: core did not halt within %0d cycles", t, HALT_CYCLES);
            end else begin
                check_value("transfer count", exp_count, seen);
                $display("Test %0d: %0d instructions, %0d executed, %0d transfers, %0d errors",
                         t, n_instr, steps, seen, errors - errors_before);
            end
        end
        $display("Tests run %0d, checks %0d, errors %0d", t, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
x86_isa_pkg.sv
x86_core_pkg.sv
x86_alu.sv
x86_regfile.sv
x86_opcode_decoder.sv
x86_sequencer.sv
x86_core.sv
tb_x86_core_sva.sv
tb_x86_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_x86_core
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
